//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_spi_axi_bridge
FILELIST = spi_axi_bridge.f

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- bench/tb_spi_axi_bridge.sv
// SPI to AXI4-Lite bridge testbench
`timescale 1ns/1ps

module tb_spi_axi_bridge;
    import spi_axi_pkg::*;

    localparam logic [31:0] SEED = 32'ha401_82e7;

    // DUT pins with AXI inputs owned by the slave model
    logic        axi_aclk = 1'b0;
    logic        i_reset;
    logic        i_spi_sck;
    logic        i_spi_ss_n;
    logic        i_spi_mosi;
    logic        o_spi_miso;
    logic [31:0] o_axi_awaddr;
    logic        o_axi_awvalid;
    logic        i_axi_awready = 1'b0;
    logic [31:0] o_axi_wdata;
    logic        o_axi_wvalid;
    logic        i_axi_wready = 1'b0;
    logic [1:0]  i_axi_bresp = 2'b00;
    logic        i_axi_bvalid = 1'b0;
    logic        o_axi_bready;
    logic [31:0] o_axi_araddr;
    logic        o_axi_arvalid;
    logic        i_axi_arready = 1'b0;
    logic [31:0] i_axi_rdata = 32'h0;
    logic [1:0]  i_axi_rresp = 2'b00;
    logic        i_axi_rvalid = 1'b0;
    logic        o_axi_rready;

    // Frame buffers with room for overrun bytes
    logic [7:0]  tx_bytes [0:12];
    logic [7:0]  rx_bytes [0:12];
    // Slave memory and the expected copy
    logic [31:0] mem [0:15];
    logic [31:0] ref_mem [0:15];

    logic [31:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_errors = 0;

    // Per-frame slave behavior chosen by the test
    int          dly_aw;
    int          dly_w;
    int          dly_ar;
    int          dly_resp;
    logic [1:0]  resp_sel;
    logic        stall = 1'b0;

    // Slave model state
    int          aw_cnt = 0;
    int          w_cnt = 0;
    int          ar_cnt = 0;
    int          aw_wait;
    int          w_wait;
    int          ar_wait;
    int          b_wait;
    int          r_wait;
    logic        have_aw;
    logic        have_w;
    logic        b_pend;
    logic        r_pend;
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic [31:0] ar_addr;
    // DUT outputs as held during the last cycle
    logic        awv_q;
    logic        wv_q;
    logic        bready_q;
    logic        arv_q;
    logic        rready_q;

    spi_axi_bridge UUT (.*);

    always #50 axi_aclk = ~axi_aclk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        take_bits = v;
    endfunction

    // Every index bit shows up in the word
    function automatic logic [31:0] fill_word(input int idx);
        logic [3:0] a;
        a         = 4'(idx);
        fill_word = {4{a, ~a}};
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge axi_aclk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    task automatic pick_delays;
        dly_aw   = int'(take_bits(3) % 6);
        dly_w    = int'(take_bits(3) % 6);
        dly_ar   = int'(take_bits(3) % 6);
        dly_resp = int'(take_bits(3) % 6);
        resp_sel = 2'(take_bits(2));
    endtask

    // ------------------------------------------------------------------
    // SPI master in mode 0 with six clocks per half period
    // ------------------------------------------------------------------

    task automatic run_frame(input int nbytes);
        int i;
        int b;
        i_spi_ss_n = 1'b0;
        wait_clocks(6);
        for (i = 0; i < nbytes; i++) begin
            for (b = 7; b >= 0; b--) begin
                // MOSI moves with the falling edge
                i_spi_mosi = tx_bytes[i][b];
                wait_clocks(6);
                i_spi_sck      = 1'b1;
                rx_bytes[i][b] = o_spi_miso;
                wait_clocks(6);
                i_spi_sck = 1'b0;
            end
        end
        wait_clocks(6);
        i_spi_ss_n = 1'b1;
    endtask

    // Abort must release the response channels
    task automatic wait_bus_released;
        int n;
        n = 0;
        while ((o_axi_bready || o_axi_rready) && n < 20) begin
            wait_clocks(1);
            n++;
        end
        if (o_axi_bready || o_axi_rready) begin
            report_failure("BREADY or RREADY still high after slave select was released");
        end
        wait_clocks(8);
    endtask

    task automatic check_status;
        if (stall) begin
            check("status timeout bit", 32'd1,
                  32'(rx_bytes[STATUS_BYTE][STATUS_TIMEOUT_BIT]));
            check("status upper bits", 32'd0, 32'(rx_bytes[STATUS_BYTE][7:3]));
        end else begin
            // Response in bits 1:0 and nothing else set
            check("status byte", 32'(resp_sel), 32'(rx_bytes[STATUS_BYTE]));
        end
    endtask

    task automatic write_frame(input logic [31:0] addr, input logic [31:0] data,
                               input int nbytes);
        int i;
        int aw0;
        int w0;
        int ar0;
        for (i = 0; i < 13; i++) begin
            tx_bytes[i] = 8'hff;
        end
        tx_bytes[0] = CMD_WRITE;
        for (i = 0; i < 4; i++) begin
            tx_bytes[1 + i] = addr[8*(3-i) +: 8];
            tx_bytes[5 + i] = data[8*(3-i) +: 8];
        end
        pick_delays();
        aw0 = aw_cnt;
        w0  = w_cnt;
        ar0 = ar_cnt;
        run_frame(nbytes);
        wait_bus_released();
        ref_mem[addr[5:2]] = data;
        check("AW handshake count", 32'd1, 32'(aw_cnt - aw0));
        check("W handshake count", 32'd1, 32'(w_cnt - w0));
        check("AR handshake count", 32'd0, 32'(ar_cnt - ar0));
        check("AWADDR", addr, aw_addr);
        check($sformatf("memory word %0d", addr[5:2]), ref_mem[addr[5:2]], mem[addr[5:2]]);
        // Only the status byte carries anything
        for (i = 0; i < nbytes; i++) begin
            if (i != STATUS_BYTE) begin
                check($sformatf("MISO byte %0d", i), 32'd0, 32'(rx_bytes[i]));
            end
        end
        check_status();
    endtask

    task automatic read_frame(input logic [31:0] addr, input int nbytes);
        int i;
        int ar0;
        int aw0;
        int w0;
        for (i = 0; i < 13; i++) begin
            tx_bytes[i] = 8'hff;
        end
        tx_bytes[0] = CMD_READ;
        for (i = 0; i < 4; i++) begin
            tx_bytes[1 + i] = addr[8*(3-i) +: 8];
        end
        pick_delays();
        ar0 = ar_cnt;
        aw0 = aw_cnt;
        w0  = w_cnt;
        run_frame(nbytes);
        wait_bus_released();
        check("AR handshake count", 32'd1, 32'(ar_cnt - ar0));
        check("AW handshake count", 32'd0, 32'(aw_cnt - aw0));
        check("W handshake count", 32'd0, 32'(w_cnt - w0));
        check("ARADDR", addr, ar_addr);
        for (i = 0; i < nbytes; i++) begin
            if (i >= RDATA_FIRST_BYTE && i < STATUS_BYTE) begin
                // Word goes MSB first and is stale when stalled
                if (!stall) begin
                    check($sformatf("read data byte %0d", i),
                          32'(ref_mem[addr[5:2]][8*(3-(i-RDATA_FIRST_BYTE)) +: 8]),
                          32'(rx_bytes[i]));
                end
            end else if (i != STATUS_BYTE) begin
                check($sformatf("MISO byte %0d", i), 32'd0, 32'(rx_bytes[i]));
            end
        end
        check_status();
    endtask

    // ------------------------------------------------------------------
    // AXI4-Lite slave model acting 1 ns after each edge
    // ------------------------------------------------------------------

    always @(posedge axi_aclk) begin : slave_model
        int k;
        #1;
        if (i_reset) begin
            for (k = 0; k < 16; k++) begin
                mem[k] = fill_word(k);
            end
            {have_aw, have_w, b_pend, r_pend} = '0;
            {i_axi_awready, i_axi_wready, i_axi_arready} = '0;
            {i_axi_bvalid, i_axi_rvalid} = '0;
            {awv_q, wv_q, bready_q, arv_q, rready_q} = '0;
        end else begin
            // Handshakes at the edge just passed
            if (awv_q && i_axi_awready) begin
                aw_cnt++;
                aw_addr       = o_axi_awaddr;
                have_aw       = 1'b1;
                i_axi_awready = 1'b0;
            end
            if (wv_q && i_axi_wready) begin
                w_cnt++;
                w_data       = o_axi_wdata;
                have_w       = 1'b1;
                i_axi_wready = 1'b0;
            end
            if (have_aw && have_w) begin
                mem[aw_addr[5:2]] = w_data;
                {have_aw, have_w} = '0;
                b_pend = 1'b1;
                b_wait = dly_resp;
            end
            if (bready_q && i_axi_bvalid) begin
                i_axi_bvalid = 1'b0;
            end
            if (arv_q && i_axi_arready) begin
                ar_cnt++;
                ar_addr       = o_axi_araddr;
                i_axi_arready = 1'b0;
                r_pend        = 1'b1;
                r_wait        = dly_resp;
            end
            if (rready_q && i_axi_rvalid) begin
                i_axi_rvalid = 1'b0;
            end
            // Stalled responses never come
            if (stall) begin
                {b_pend, r_pend} = '0;
            end
            // Ready delays reload while a channel is idle
            if (!o_axi_awvalid) begin
                aw_wait = dly_aw;
            end else if (!i_axi_awready && aw_wait == 0) begin
                i_axi_awready = 1'b1;
            end else if (!i_axi_awready) begin
                aw_wait--;
            end
            if (!o_axi_wvalid) begin
                w_wait = dly_w;
            end else if (!i_axi_wready && w_wait == 0) begin
                i_axi_wready = 1'b1;
            end else if (!i_axi_wready) begin
                w_wait--;
            end
            if (!o_axi_arvalid) begin
                ar_wait = dly_ar;
            end else if (!i_axi_arready && ar_wait == 0) begin
                i_axi_arready = 1'b1;
            end else if (!i_axi_arready) begin
                ar_wait--;
            end
            if (b_pend && b_wait == 0) begin
                i_axi_bvalid = 1'b1;
                i_axi_bresp  = resp_sel;
                b_pend       = 1'b0;
            end else if (b_pend) begin
                b_wait--;
            end
            if (r_pend && r_wait == 0) begin
                i_axi_rvalid = 1'b1;
                i_axi_rresp  = resp_sel;
                i_axi_rdata  = mem[ar_addr[5:2]];
                r_pend       = 1'b0;
            end else if (r_pend) begin
                r_wait--;
            end
            awv_q    = o_axi_awvalid;
            wv_q     = o_axi_wvalid;
            bready_q = o_axi_bready;
            arv_q    = o_axi_arvalid;
            rready_q = o_axi_rready;
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        int n;
        logic [31:0] a;
        logic [31:0] d;
        i_reset    = 1'b1;
        i_spi_sck  = 1'b0;
        i_spi_ss_n = 1'b1;
        i_spi_mosi = 1'b0;
        lfsr       = SEED;
        for (n = 0; n < 16; n++) begin
            ref_mem[n] = fill_word(n);
        end
        repeat (5) @(posedge axi_aclk);
        #1;
        i_reset = 1'b0;
        wait_clocks(4);

        // Writes with memory and status checks
        for (n = 0; n < 8; n++) begin
            a = take_bits(32);
            d = take_bits(32);
            write_frame(a, d, FRAME_BYTES);
        end
        finish_test("random writes");

        for (n = 0; n < 8; n++) begin
            a = take_bits(32);
            read_frame(a, FRAME_BYTES);
        end
        finish_test("random reads");

        // Withheld responses followed by a clean pair
        a     = take_bits(32);
        d     = take_bits(32);
        stall = 1'b1;
        write_frame(a, d, FRAME_BYTES);
        read_frame(a, FRAME_BYTES);
        stall = 1'b0;
        d = take_bits(32);
        write_frame(a, d, FRAME_BYTES);
        read_frame(a, FRAME_BYTES);
        finish_test("timeout");

        // Two extra bytes past the frame
        a = take_bits(32);
        d = take_bits(32);
        write_frame(a, d, FRAME_BYTES + 2);
        read_frame(a, FRAME_BYTES + 2);
        finish_test("overrun");

        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- hdl/axi_lite_master.sv
// AXI4-Lite single access master
`timescale 1ns/1ps

module axi_lite_master (
    input  logic                              axi_aclk,
    input  logic                              i_reset,
    input  logic                              i_abort_n,
    input  spi_axi_pkg::spi_req_t             i_req,
    input  logic                              i_req_valid,
    // Write address
    output logic [spi_axi_pkg::ADDR_W-1:0]    o_axi_awaddr,
    output logic                              o_axi_awvalid,
    input  logic                              i_axi_awready,
    // Write data
    output logic [spi_axi_pkg::DATA_W-1:0]    o_axi_wdata,
    output logic                              o_axi_wvalid,
    input  logic                              i_axi_wready,
    // Write response
    input  logic [1:0]                        i_axi_bresp,
    input  logic                              i_axi_bvalid,
    output logic                              o_axi_bready,
    // Read address
    output logic [spi_axi_pkg::ADDR_W-1:0]    o_axi_araddr,
    output logic                              o_axi_arvalid,
    input  logic                              i_axi_arready,
    // Read data
    input  logic [spi_axi_pkg::DATA_W-1:0]    i_axi_rdata,
    input  logic [1:0]                        i_axi_rresp,
    input  logic                              i_axi_rvalid,
    output logic                              o_axi_rready,
    // Captured response
    output spi_axi_pkg::axi_result_t          o_result
);
    import spi_axi_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_ACK,
        ST_WRITE_RESP,
        ST_READ_ADDR,
        ST_READ_DATA
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    // Channel finished now or earlier
    logic              aw_done;
    logic              w_done;

    assign aw_done = !o_axi_awvalid || i_axi_awready;
    assign w_done  = !o_axi_wvalid || i_axi_wready;

    // Request payload, taken when the access starts
    always_ff @(posedge axi_aclk) begin
        if (i_req_valid && state == ST_IDLE) begin
            addr_q  <= i_req.addr;
            wdata_q <= i_req.wdata;
        end
    end

    // ------------------------------------------------------------------
    // Access FSM
    // ------------------------------------------------------------------

    always_ff @(posedge axi_aclk or posedge i_reset) begin
        if (i_reset) begin
            state         <= ST_IDLE;
            o_axi_awvalid <= 1'b0;
            o_axi_wvalid  <= 1'b0;
            o_axi_bready  <= 1'b0;
            o_axi_arvalid <= 1'b0;
            o_axi_rready  <= 1'b0;
            o_result      <= '0;
        end else if (!i_abort_n) begin
            // Select gone, drop whatever is pending
            state          <= ST_IDLE;
            o_axi_awvalid  <= 1'b0;
            o_axi_wvalid   <= 1'b0;
            o_axi_bready   <= 1'b0;
            o_axi_arvalid  <= 1'b0;
            o_axi_rready   <= 1'b0;
            o_result.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req_valid) begin
                        o_result.valid <= 1'b0;
                        if (i_req.is_write) begin
                            // AW and W together
                            o_axi_awvalid <= 1'b1;
                            o_axi_wvalid  <= 1'b1;
                            state         <= ST_WRITE_ACK;
                        end else begin
                            o_axi_arvalid <= 1'b1;
                            state         <= ST_READ_ADDR;
                        end
                    end
                end
                ST_WRITE_ACK: begin
                    if (i_axi_awready) begin
                        o_axi_awvalid <= 1'b0;
                    end
                    if (i_axi_wready) begin
                        o_axi_wvalid <= 1'b0;
                    end
                    // Both accepted, in any order
                    if (aw_done && w_done) begin
                        o_axi_bready <= 1'b1;
                        state        <= ST_WRITE_RESP;
                    end
                end
                ST_WRITE_RESP: begin
                    if (i_axi_bvalid) begin
                        o_axi_bready   <= 1'b0;
                        o_result.valid <= 1'b1;
                        o_result.resp  <= i_axi_bresp;
                        state          <= ST_IDLE;
                    end
                end
                ST_READ_ADDR: begin
                    if (i_axi_arready) begin
                        o_axi_arvalid <= 1'b0;
                        o_axi_rready  <= 1'b1;
                        state         <= ST_READ_DATA;
                    end
                end
                ST_READ_DATA: begin
                    if (i_axi_rvalid) begin
                        o_axi_rready   <= 1'b0;
                        o_result.valid <= 1'b1;
                        o_result.resp  <= i_axi_rresp;
                        o_result.rdata <= i_axi_rdata;
                        state          <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // One address register serves both channels
    assign o_axi_awaddr = addr_q;
    assign o_axi_araddr = addr_q;
    assign o_axi_wdata  = wdata_q;

endmodule

//--- hdl/spi_axi_bridge.sv
// SPI to AXI4-Lite bridge top level
`timescale 1ns/1ps

module spi_axi_bridge (
    input  logic                           axi_aclk,
    input  logic                           i_reset,
    // SPI slave pins
    input  logic                           i_spi_sck,
    input  logic                           i_spi_ss_n,
    input  logic                           i_spi_mosi,
    output logic                           o_spi_miso,
    // Write address
    output logic [spi_axi_pkg::ADDR_W-1:0] o_axi_awaddr,
    output logic                           o_axi_awvalid,
    input  logic                           i_axi_awready,
    // Write data
    output logic [spi_axi_pkg::DATA_W-1:0] o_axi_wdata,
    output logic                           o_axi_wvalid,
    input  logic                           i_axi_wready,
    // Write response
    input  logic [1:0]                     i_axi_bresp,
    input  logic                           i_axi_bvalid,
    output logic                           o_axi_bready,
    // Read address
    output logic [spi_axi_pkg::ADDR_W-1:0] o_axi_araddr,
    output logic                           o_axi_arvalid,
    input  logic                           i_axi_arready,
    // Read data
    input  logic [spi_axi_pkg::DATA_W-1:0] i_axi_rdata,
    input  logic [1:0]                     i_axi_rresp,
    input  logic                           i_axi_rvalid,
    output logic                           o_axi_rready
);
    import spi_axi_pkg::*;

    spi_edges_t  edges;
    spi_req_t    req;
    logic        req_valid;
    axi_result_t result;

    // ------------------------------------------------------------------
    // SPI side
    // ------------------------------------------------------------------

    spi_sck_sync u_sync (
        .axi_aclk   (axi_aclk),
        .i_reset    (i_reset),
        .i_spi_sck  (i_spi_sck),
        .i_spi_ss_n (i_spi_ss_n),
        .o_edges    (edges)
    );

    spi_frame_rx u_rx (
        .axi_aclk    (axi_aclk),
        .i_reset     (i_reset),
        .i_edges     (edges),
        .i_spi_mosi  (i_spi_mosi),
        .o_req       (req),
        .o_req_valid (req_valid)
    );

    spi_frame_tx u_tx (
        .axi_aclk   (axi_aclk),
        .i_reset    (i_reset),
        .i_edges    (edges),
        .i_is_write (req.is_write),
        .i_result   (result),
        .o_spi_miso (o_spi_miso)
    );

    // ------------------------------------------------------------------
    // AXI side, aborted when select drops
    // ------------------------------------------------------------------

    axi_lite_master u_axi (
        .axi_aclk      (axi_aclk),
        .i_reset       (i_reset),
        .i_abort_n     (edges.selected),
        .i_req         (req),
        .i_req_valid   (req_valid),
        .o_axi_awaddr  (o_axi_awaddr),
        .o_axi_awvalid (o_axi_awvalid),
        .i_axi_awready (i_axi_awready),
        .o_axi_wdata   (o_axi_wdata),
        .o_axi_wvalid  (o_axi_wvalid),
        .i_axi_wready  (i_axi_wready),
        .i_axi_bresp   (i_axi_bresp),
        .i_axi_bvalid  (i_axi_bvalid),
        .o_axi_bready  (o_axi_bready),
        .o_axi_araddr  (o_axi_araddr),
        .o_axi_arvalid (o_axi_arvalid),
        .i_axi_arready (i_axi_arready),
        .i_axi_rdata   (i_axi_rdata),
        .i_axi_rresp   (i_axi_rresp),
        .i_axi_rvalid  (i_axi_rvalid),
        .o_axi_rready  (o_axi_rready),
        .o_result      (result)
    );

endmodule

//--- hdl/spi_axi_pkg.sv
// SPI to AXI4-Lite bridge definitions
package spi_axi_pkg;

    // ------------------------------------------------------------------
    // Frame layout
    // ------------------------------------------------------------------

    // Command byte values
    localparam logic [7:0] CMD_WRITE = 8'h00;
    localparam logic [7:0] CMD_READ  = 8'h01;

    // Byte positions within one frame
    localparam int FRAME_BYTES      = 11;
    localparam int ADDR_LAST_BYTE   = 4;
    localparam int WDATA_LAST_BYTE  = 8;
    localparam int RDATA_FIRST_BYTE = 6;
    localparam int STATUS_BYTE      = 10;

    // Status byte, bits 1:0 hold the AXI response
    localparam int STATUS_TIMEOUT_BIT = 2;

    // Bus widths
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BYTE_IDX_W = 4;

    // ------------------------------------------------------------------
    // Shared types
    // ------------------------------------------------------------------

    typedef logic [BYTE_IDX_W-1:0] byte_idx_t;

    // SCK edge strobes and select level, all in the axi_aclk domain
    typedef struct packed {
        logic sample;
        logic drive;
        logic selected;
    } spi_edges_t;

    // One access as decoded from the frame
    typedef struct packed {
        logic              is_write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } spi_req_t;

    // Outcome of the last AXI access
    typedef struct packed {
        logic              valid;
        logic [1:0]        resp;
        logic [DATA_W-1:0] rdata;
    } axi_result_t;

endpackage

//--- hdl/spi_frame_rx.sv
// SPI frame receiver
`timescale 1ns/1ps

module spi_frame_rx (
    input  logic                    axi_aclk,
    input  logic                    i_reset,
    input  spi_axi_pkg::spi_edges_t i_edges,
    input  logic                    i_spi_mosi,
    output spi_axi_pkg::spi_req_t   o_req,
    output logic                    o_req_valid
);
    import spi_axi_pkg::*;

    logic [2:0]        bit_cnt;
    byte_idx_t         byte_cnt;
    logic [7:0]        rx_shreg;
    logic [7:0]        cmd_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;

    // Byte as it stands after the current sample
    logic [7:0]        rx_byte;
    logic              byte_done;

    // MOSI taken straight, it is stable around the sample edge
    assign rx_byte   = {rx_shreg[6:0], i_spi_mosi};
    // Last bit of a byte, overrun bytes not counted
    assign byte_done = i_edges.sample && (bit_cnt == 3'd7) &&
                       (byte_cnt < byte_idx_t'(FRAME_BYTES));

    // ------------------------------------------------------------------
    // Bit and byte counters
    // ------------------------------------------------------------------

    always_ff @(posedge axi_aclk or posedge i_reset) begin
        if (i_reset) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rx_shreg <= '0;
        end else if (!i_edges.selected) begin
            // Frame boundary
            bit_cnt  <= '0;
            byte_cnt <= '0;
            rx_shreg <= '0;
        end else if (i_edges.sample) begin
            rx_shreg <= rx_byte;
            bit_cnt  <= bit_cnt + 3'd1;
            if (byte_done) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Command decode and request strobe
    // ------------------------------------------------------------------

    always_ff @(posedge axi_aclk or posedge i_reset) begin
        if (i_reset) begin
            cmd_q       <= '0;
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= 1'b0;
            if (byte_done) begin
                if (byte_cnt == '0) begin
                    cmd_q <= rx_byte;
                end
                // Write fires once the data is in
                if (cmd_q == CMD_WRITE && byte_cnt == WDATA_LAST_BYTE) begin
                    o_req_valid <= 1'b1;
                end
                // Read fires right after the address
                if (cmd_q == CMD_READ && byte_cnt == ADDR_LAST_BYTE) begin
                    o_req_valid <= 1'b1;
                end
            end
        end
    end

    // Address and data, MSB first
    always_ff @(posedge axi_aclk) begin
        if (byte_done && byte_cnt != '0) begin
            if (byte_cnt <= ADDR_LAST_BYTE) begin
                addr_q <= {addr_q[ADDR_W-9:0], rx_byte};
            end else if (cmd_q == CMD_WRITE && byte_cnt <= WDATA_LAST_BYTE) begin
                wdata_q <= {wdata_q[DATA_W-9:0], rx_byte};
            end
        end
    end

    assign o_req.is_write = (cmd_q == CMD_WRITE);
    assign o_req.addr     = addr_q;
    assign o_req.wdata    = wdata_q;

endmodule

//--- hdl/spi_frame_tx.sv
// SPI frame transmitter
`timescale 1ns/1ps

module spi_frame_tx (
    input  logic                     axi_aclk,
    input  logic                     i_reset,
    input  spi_axi_pkg::spi_edges_t  i_edges,
    input  logic                     i_is_write,
    input  spi_axi_pkg::axi_result_t i_result,
    output logic                     o_spi_miso
);
    import spi_axi_pkg::*;

    logic [2:0] bit_cnt;
    byte_idx_t  byte_cnt;
    logic [7:0] tx_shreg;
    // Load one cycle after a byte ends
    logic       load_q;
    logic [7:0] tx_byte;
    logic [7:0] status;

    // ------------------------------------------------------------------
    // Next byte select
    // ------------------------------------------------------------------

    always_comb begin
        // Timeout if no response yet, upper bits zero
        status                     = '0;
        status[STATUS_TIMEOUT_BIT] = ~i_result.valid;
        status[1:0]                = i_result.resp;

        tx_byte = '0;
        if (byte_cnt == STATUS_BYTE) begin
            tx_byte = status;
        end else if (!i_is_write && byte_cnt >= RDATA_FIRST_BYTE &&
                     byte_cnt < STATUS_BYTE) begin
            // Read data, MSB first
            tx_byte = i_result.rdata[8*(STATUS_BYTE-1-int'(byte_cnt)) +: 8];
        end
    end

    // ------------------------------------------------------------------
    // Shift register and counters
    // ------------------------------------------------------------------

    always_ff @(posedge axi_aclk or posedge i_reset) begin
        if (i_reset) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            tx_shreg <= '0;
            load_q   <= 1'b0;
        end else if (!i_edges.selected) begin
            // Byte 0 goes out as zero
            bit_cnt  <= '0;
            byte_cnt <= '0;
            tx_shreg <= '0;
            load_q   <= 1'b0;
        end else begin
            load_q <= 1'b0;
            if (load_q) begin
                tx_shreg <= tx_byte;
            end else if (i_edges.drive) begin
                tx_shreg <= {tx_shreg[6:0], 1'b0};
                bit_cnt  <= bit_cnt + 3'd1;
                // No loads past the status byte, overrun shifts zeros
                if (bit_cnt == 3'd7 && byte_cnt < byte_idx_t'(FRAME_BYTES - 1)) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    load_q   <= 1'b1;
                end
            end
        end
    end

    assign o_spi_miso = tx_shreg[7];

endmodule

//--- hdl/spi_sck_sync.sv
// SPI clock and select synchronizer
`timescale 1ns/1ps

module spi_sck_sync (
    input  logic                    axi_aclk,
    input  logic                    i_reset,
    input  logic                    i_spi_sck,
    input  logic                    i_spi_ss_n,
    output spi_axi_pkg::spi_edges_t o_edges
);

    // Two flops per pin, plus one for edge detection
    logic sck_meta;
    logic sck_sync;
    logic sck_dly;
    logic ss_n_meta;
    logic ss_n_sync;

    // Registered edge strobes
    logic sample_q;
    logic drive_q;

    always_ff @(posedge axi_aclk or posedge i_reset) begin
        if (i_reset) begin
            // Idle levels, SCK low and select inactive
            sck_meta  <= 1'b0;
            sck_sync  <= 1'b0;
            sck_dly   <= 1'b0;
            ss_n_meta <= 1'b1;
            ss_n_sync <= 1'b1;
            sample_q  <= 1'b0;
            drive_q   <= 1'b0;
        end else begin
            sck_meta  <= i_spi_sck;
            sck_sync  <= sck_meta;
            sck_dly   <= sck_sync;
            ss_n_meta <= i_spi_ss_n;
            ss_n_sync <= ss_n_meta;
            // Mode 0, sample on rising SCK
            sample_q  <= sck_sync & ~sck_dly & ~ss_n_sync;
            // Drive on falling SCK
            drive_q   <= ~sck_sync & sck_dly & ~ss_n_sync;
        end
    end

    assign o_edges.sample   = sample_q;
    assign o_edges.drive    = drive_q;
    assign o_edges.selected = ~ss_n_sync;

endmodule

//--- spi_axi_bridge.f
hdl/spi_axi_pkg.sv
hdl/spi_sck_sync.sv
hdl/spi_frame_rx.sv
hdl/spi_frame_tx.sv
hdl/axi_lite_master.sv
hdl/spi_axi_bridge.sv
bench/tb_spi_axi_bridge.sv
